// ==== lsu_pkg.sv ====
// Shared widths, limits and access encodings for the load/store unit
// Referenced by scoped name from every LSU module
package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;  // Byte address
  localparam int DATA_W = 32;  // One bus word
  localparam int BE_W   = 4;   // One enable per byte lane

  //////////////////////////////////////////////////////////////////////
  // Transaction tracking
  //////////////////////////////////////////////////////////////////////

  // Accepted requests still waiting for rvalid
  localparam int MAX_OUTSTANDING = 2;
  localparam int CNT_W           = 2;  // Holds 0 .. MAX_OUTSTANDING

  //////////////////////////////////////////////////////////////////////
  // Access encodings
  //////////////////////////////////////////////////////////////////////

  // Access size from the execute stage
  // Codes 2'b10 and 2'b11 are both treated as a byte
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } mem_size_e;

  // Fill applied above a loaded byte or halfword
  // Spare code 2'b11 extends the sign, same as EXT_SIGN
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,  // Unsigned loads
    EXT_SIGN = 2'b01,  // Signed loads
    EXT_ONES = 2'b10   // Upper bits forced high
  } ext_mode_e;

  // Lane mask of an access placed at offset zero
  // Shifted by the byte offset in the request formatter
  //   word -> 1111
  //   half -> 0011
  //   byte -> 0001
  // A mask that runs past lane 3 spills into the next word, which is
  // what makes an access misaligned

endpackage

// ==== lsu_req_format.sv ====
// Request formatter of the LSU: address, byte enables, store data lanes
// Purely combinational, sits between the execute stage and the bus controller
`timescale 1ns/1ps

module lsu_req_format (
  input  logic                           data_req_ex_i,        // Access pending in EX
  input  logic                           data_we_ex_i,         // Store when high
  input  lsu_pkg::mem_size_e             data_type_ex_i,       // Word, half or byte
  input  logic [lsu_pkg::DATA_W-1:0]     data_wdata_ex_i,      // Store data as in the register
  input  logic [1:0]                     data_reg_offset_ex_i, // Byte offset inside the register
  input  logic [lsu_pkg::ADDR_W-1:0]     operand_a_ex_i,       // Base
  input  logic [lsu_pkg::ADDR_W-1:0]     operand_b_ex_i,       // Increment
  input  logic                           addr_useincr_ex_i,    // A+B when high, else A
  input  logic                           data_misaligned_ex_i, // Second phase of a split access

  output logic [lsu_pkg::ADDR_W-1:0]     trans_addr_o,
  output logic                           trans_we_o,
  output logic [lsu_pkg::BE_W-1:0]       trans_be_o,
  output logic [lsu_pkg::DATA_W-1:0]     trans_wdata_o,
  output logic [1:0]                     addr_offset_o,        // Byte offset, kept by the aligner
  output logic                           data_misaligned_o     // Ask EX for a second phase
);

  logic [lsu_pkg::ADDR_W-1:0]   addr_int;     // Raw effective address
  logic [1:0]                   offset;       // Byte lane of the first byte
  logic [lsu_pkg::BE_W-1:0]     size_mask;    // Lanes used at offset zero
  logic [2*lsu_pkg::BE_W-1:0]   be_span;      // Mask over two consecutive words
  logic [1:0]                   wdata_offset; // Rotation in bytes
  logic [2*lsu_pkg::DATA_W-1:0] wdata_dbl;    // Doubled word for the rotate

  //////////////////////////////////////////////////////////////////////
  // Address
  //////////////////////////////////////////////////////////////////////

  assign addr_int = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign offset   = addr_int[1:0];

  // Second phase always starts at lane 0 of the next word
  assign trans_addr_o  = data_misaligned_ex_i ? {addr_int[lsu_pkg::ADDR_W-1:2], 2'b00}
                                              : addr_int;
  assign trans_we_o    = data_we_ex_i;
  assign addr_offset_o = offset;

  //////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (data_type_ex_i)
      lsu_pkg::SIZE_WORD: size_mask = 4'b1111;
      lsu_pkg::SIZE_HALF: size_mask = 4'b0011;
      default:            size_mask = 4'b0001;  // Both byte codes
    endcase
  end

  // Low half is the first word, high half what spills into the next one
  assign be_span = {{lsu_pkg::BE_W{1'b0}}, size_mask} << offset;

  assign trans_be_o = data_misaligned_ex_i ? be_span[2*lsu_pkg::BE_W-1:lsu_pkg::BE_W]
                                           : be_span[lsu_pkg::BE_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Store data
  //////////////////////////////////////////////////////////////////////

  // Register byte at reg_offset must land on lane offset
  assign wdata_offset = offset - data_reg_offset_ex_i;
  assign wdata_dbl    = {data_wdata_ex_i, data_wdata_ex_i} << {wdata_offset, 3'b000};

  // Upper copy holds the rotated word, wrap-around included
  assign trans_wdata_o = wdata_dbl[2*lsu_pkg::DATA_W-1:lsu_pkg::DATA_W];

  //////////////////////////////////////////////////////////////////////
  // Misalignment
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin  // Only flagged in the first phase
      case (data_type_ex_i)
        lsu_pkg::SIZE_WORD: data_misaligned_o = (offset != 2'b00);
        lsu_pkg::SIZE_HALF: data_misaligned_o = (offset == 2'b11);
        default:            data_misaligned_o = 1'b0;  // A byte never crosses
      endcase
    end
  end

  // Fields handed to the bus must be clean whenever EX asks for an access
  always_comb begin
    if (data_req_ex_i) begin
      a_fields_known: assert final (!$isunknown({trans_addr_o, trans_we_o, trans_be_o}) &&
                                    !(trans_we_o && $isunknown(trans_wdata_o)))
        else $error("LSU request fields unknown while data_req_ex_i is high");
    end
  end

endmodule

// ==== lsu_trans_ctrl.sv ====
// Bus transaction controller of the LSU
// Issues req/gnt requests, tracks outstanding responses and drives EX/WB ready
`timescale 1ns/1ps

module lsu_trans_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         data_req_ex_i,  // Access pending in EX
  input  logic [lsu_pkg::ADDR_W-1:0]   trans_addr_i,
  input  logic                         trans_we_i,
  input  logic [lsu_pkg::BE_W-1:0]     trans_be_i,
  input  logic [lsu_pkg::DATA_W-1:0]   trans_wdata_i,

  // Data bus
  output logic                         data_req_o,
  input  logic                         data_gnt_i,
  input  logic                         data_rvalid_i,
  output logic [lsu_pkg::ADDR_W-1:0]   data_addr_o,
  output logic                         data_we_o,
  output logic [lsu_pkg::BE_W-1:0]     data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]   data_wdata_o,

  output logic                         resp_valid_o,   // Response for the aligner
  output logic                         ctrl_update_o,  // EX advances into WB
  output logic                         lsu_ready_ex_o,
  output logic                         lsu_ready_wb_o,
  output logic                         busy_o
);

  logic [lsu_pkg::CNT_W-1:0] cnt_q;     // Outstanding transactions
  logic [lsu_pkg::CNT_W-1:0] cnt_d;
  logic                      accepted;  // req and gnt in the same cycle
  logic                      cnt_zero;
  logic                      cnt_one;

  //////////////////////////////////////////////////////////////////////
  // Request issue
  //////////////////////////////////////////////////////////////////////

  // No path from rvalid to req, so a full counter simply holds req low
  assign data_req_o   = data_req_ex_i && (cnt_q < lsu_pkg::MAX_OUTSTANDING);
  assign data_addr_o  = trans_addr_i;   // EX holds these until ready
  assign data_we_o    = trans_we_i;
  assign data_be_o    = trans_be_i;
  assign data_wdata_o = trans_wdata_i;

  assign accepted     = data_req_o && data_gnt_i;
  assign resp_valid_o = data_rvalid_i;

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    case ({accepted, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;  // New request only
      2'b01:   cnt_d = cnt_q - 1'b1;  // Response only
      default: cnt_d = cnt_q;         // Idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign cnt_zero = (cnt_q == '0);
  assign cnt_one  = (cnt_q == lsu_pkg::CNT_W'(1));

  //////////////////////////////////////////////////////////////////////
  // Ready and busy
  //////////////////////////////////////////////////////////////////////

  // WB is free when empty, otherwise once its response is back
  assign lsu_ready_wb_o = cnt_zero ? 1'b1 : data_rvalid_i;

  // EX and WB move in lock step once WB holds an access
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;                       // Nothing to issue
    end else if (cnt_zero) begin
      lsu_ready_ex_o = accepted;
    end else if (cnt_one) begin
      lsu_ready_ex_o = accepted && data_rvalid_i;
    end else begin
      lsu_ready_ex_o = data_rvalid_i;              // Full, req is held low
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;

  assign busy_o = !cnt_zero || data_req_o;

  // Counter bounds against the bus protocol
  a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= lsu_pkg::MAX_OUTSTANDING);

  // Memory side must not answer a request it never granted
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> !cnt_zero);

endmodule

// ==== lsu_rdata_align.sv ====
// Load data aligner of the LSU: lane select, extension and misaligned join
// Control captured when EX advances, result returned on rvalid
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         ctrl_update_i,        // EX advances into WB
  input  logic                         resp_valid_i,         // rvalid from the bus
  input  logic [lsu_pkg::DATA_W-1:0]   data_rdata_i,

  input  lsu_pkg::mem_size_e           data_type_ex_i,
  input  lsu_pkg::ext_mode_e           data_sign_ext_ex_i,
  input  logic                         data_we_ex_i,
  input  logic [1:0]                   addr_offset_i,        // From the formatter
  input  logic                         data_misaligned_ex_i, // EX is in the second phase
  input  logic                         data_misaligned_i,    // First phase of a split access

  output logic [lsu_pkg::DATA_W-1:0]   data_rdata_ex_o
);

  // WB copy of the access control
  lsu_pkg::mem_size_e           data_type_q;
  lsu_pkg::ext_mode_e           sign_ext_q;
  logic [1:0]                   offset_q;
  logic                         we_q;

  logic [lsu_pkg::DATA_W-1:0]   rdata_q;    // Held word
  logic [2*lsu_pkg::DATA_W-1:0] join_dbl;   // New word above the held one
  logic [lsu_pkg::DATA_W-1:0]   joined;     // Access that crossed the word boundary
  logic [lsu_pkg::DATA_W-1:0]   lane;       // Access inside the new word
  logic [15:0]                  half_raw;
  logic [7:0]                   byte_raw;
  logic [lsu_pkg::DATA_W-1:0]   rdata_ext;  // Final register value

  // Bit placed above a narrow load
  function automatic logic fill_bit(input lsu_pkg::ext_mode_e mode, input logic msb);
    case (mode)
      lsu_pkg::EXT_ZERO: fill_bit = 1'b0;
      lsu_pkg::EXT_ONES: fill_bit = 1'b1;
      default:           fill_bit = msb;  // EXT_SIGN and the spare code
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_type_q <= lsu_pkg::SIZE_WORD;
      sign_ext_q  <= lsu_pkg::EXT_ZERO;
      offset_q    <= 2'b00;
      we_q        <= 1'b0;
    end else if (ctrl_update_i) begin  // Granted, waiting on rvalid
      data_type_q <= data_type_ex_i;
      sign_ext_q  <= data_sign_ext_ex_i;
      offset_q    <= addr_offset_i;
      we_q        <= data_we_ex_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane select
  //////////////////////////////////////////////////////////////////////

  // Upper bytes come from the held first word, low bytes from the new one
  assign join_dbl = {data_rdata_i, rdata_q} >> {offset_q, 3'b000};
  assign joined   = join_dbl[lsu_pkg::DATA_W-1:0];
  assign lane     = data_rdata_i >> {offset_q, 3'b000};

  assign half_raw = (offset_q == 2'b11) ? joined[15:0] : lane[15:0];  // Offset 3 crosses
  assign byte_raw = lane[7:0];

  always_comb begin
    case (data_type_q)
      lsu_pkg::SIZE_WORD:
        rdata_ext = (offset_q == 2'b00) ? data_rdata_i : joined;
      lsu_pkg::SIZE_HALF:
        rdata_ext = {{16{fill_bit(sign_ext_q, half_raw[15])}}, half_raw};
      default:
        rdata_ext = {{24{fill_bit(sign_ext_q, byte_raw[7])}}, byte_raw};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Held word
  //////////////////////////////////////////////////////////////////////

  // Raw word while a split load is in flight, result otherwise
  always_ff @(posedge clk) begin
    if (resp_valid_i && !we_q) begin
      if (data_misaligned_ex_i || data_misaligned_i) begin
        rdata_q <= data_rdata_i;  // First half, joined on the next response
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  assign data_rdata_ex_o = resp_valid_i ? rdata_ext : rdata_q;

endmodule

// ==== lsu_top.sv ====
// Top level of the data-memory load/store unit
// Connects the execute stage to a req/gnt/rvalid data bus
`timescale 1ns/1ps

module lsu_top (
  input  logic                         clk,
  input  logic                         rst_n,

  // Execute stage
  input  logic                         data_req_ex_i,
  input  logic                         data_we_ex_i,
  input  lsu_pkg::mem_size_e           data_type_ex_i,
  input  lsu_pkg::ext_mode_e           data_sign_ext_ex_i,
  input  logic [lsu_pkg::DATA_W-1:0]   data_wdata_ex_i,
  input  logic [1:0]                   data_reg_offset_ex_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   operand_a_ex_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   operand_b_ex_i,
  input  logic                         addr_useincr_ex_i,
  input  logic                         data_misaligned_ex_i,
  output logic [lsu_pkg::DATA_W-1:0]   data_rdata_ex_o,
  output logic                         data_misaligned_o,
  output logic                         lsu_ready_ex_o,
  output logic                         lsu_ready_wb_o,
  output logic                         busy_o,

  // Data bus
  output logic                         data_req_o,
  input  logic                         data_gnt_i,
  input  logic                         data_rvalid_i,
  output logic [lsu_pkg::ADDR_W-1:0]   data_addr_o,
  output logic                         data_we_o,
  output logic [lsu_pkg::BE_W-1:0]     data_be_o,
  output logic [lsu_pkg::DATA_W-1:0]   data_wdata_o,
  input  logic [lsu_pkg::DATA_W-1:0]   data_rdata_i
);

  logic [lsu_pkg::ADDR_W-1:0] trans_addr;
  logic                       trans_we;
  logic [lsu_pkg::BE_W-1:0]   trans_be;
  logic [lsu_pkg::DATA_W-1:0] trans_wdata;
  logic [1:0]                 addr_offset;  // Formatter to aligner
  logic                       resp_valid;
  logic                       ctrl_update;

  lsu_req_format u_req_format (
    .data_req_ex_i        (data_req_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .trans_addr_o         (trans_addr),
    .trans_we_o           (trans_we),
    .trans_be_o           (trans_be),
    .trans_wdata_o        (trans_wdata),
    .addr_offset_o        (addr_offset),
    .data_misaligned_o    (data_misaligned_o)
  );

  lsu_trans_ctrl u_trans_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .trans_addr_i   (trans_addr),
    .trans_we_i     (trans_we),
    .trans_be_i     (trans_be),
    .trans_wdata_i  (trans_wdata),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .resp_valid_o   (resp_valid),
    .ctrl_update_o  (ctrl_update),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .resp_valid_i         (resp_valid),
    .data_rdata_i         (data_rdata_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .addr_offset_i        (addr_offset),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .data_rdata_ex_o      (data_rdata_ex_o)
  );

endmodule

// ==== tb_lsu.sv ====
// Directed testbench for the LSU top level with a byte-addressed req/gnt/rvalid memory
// Each test task acts as the execute stage and checks the bus and load results
`timescale 1ns/1ps

module tb_lsu;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        data_req_ex_i, data_we_ex_i, addr_useincr_ex_i;
  logic                        data_misaligned_ex_i;
  lsu_pkg::mem_size_e          data_type_ex_i;
  lsu_pkg::ext_mode_e          data_sign_ext_ex_i;
  logic [31:0]                 data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  logic [1:0]                  data_reg_offset_ex_i;
  logic [31:0]                 data_rdata_ex_o, data_addr_o, data_wdata_o, data_rdata_i;
  logic                        data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;
  logic                        data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  logic [3:0]                  data_be_o;

  integer      seed;
  int          errors;
  int          cyc;
  int          gnt_wait;
  int          resp_extra;     // Extra response latency for the overlap test
  logic        block_gnt;      // Withholds grant while set
  logic [7:0]  bus_mem [logic [31:0]];  // Written by the bus
  logic [7:0]  ref_mem [logic [31:0]];  // Expected contents
  logic [31:0] resp_q [$];
  int          resp_due [$];

  lsu_top uut (.*);

  always #20 clk = ~clk;  // 40 ns period

  ////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////

  // Unwritten bytes read back a pattern of the whole address
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    fill_byte = a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5;
  endfunction

  function automatic logic [7:0] bus_byte(input logic [31:0] a);
    bus_byte = bus_mem.exists(a) ? bus_mem[a] : fill_byte(a);
  endfunction

  function automatic logic [7:0] ref_byte(input logic [31:0] a);
    ref_byte = ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
  endfunction

  always @(posedge clk) begin
    logic [31:0] rd;
    cyc = cyc + 1;
    if (!rst_n) begin
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
      gnt_wait      = 0;
    end else begin
      data_rvalid_i <= 1'b0;
      if (resp_q.size() > 0 && resp_due[0] <= cyc) begin  // In order, one per cycle
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= resp_q.pop_front();
        void'(resp_due.pop_front());
      end
      if (data_req_o && data_gnt_i) begin
        rd = '0;
        for (int k = 0; k < 4; k++) begin
          if (data_we_o && data_be_o[k])
            bus_mem[{data_addr_o[31:2], 2'(k)}] = data_wdata_o[8*k +: 8];
          rd[8*k +: 8] = bus_byte({data_addr_o[31:2], 2'(k)});
        end
        resp_q.push_back(rd);
        resp_due.push_back(cyc + 1 + resp_extra + int'($unsigned($random(seed)) % 3));
        data_gnt_i <= 1'b0;
        gnt_wait   = int'($unsigned($random(seed)) % 3);  // 0 to 2 cycles
      end else if (block_gnt || !data_req_o) begin
        data_gnt_i <= 1'b0;
      end else if (!data_gnt_i) begin
        if (gnt_wait == 0) data_gnt_i <= 1'b1;
        else gnt_wait = gnt_wait - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  task automatic flag_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // Little-endian bytes from the expected memory, then the fill rule
  function automatic logic [31:0] expect_load(input logic [31:0] a, input logic [1:0] size,
                                              input logic [1:0] ext);
    logic [31:0] v;
    logic        fill;
    int          n;
    n = (size == 2'd0) ? 4 : (size == 2'd1) ? 2 : 1;
    v = '0;
    for (int k = 0; k < n; k++) v[8*k +: 8] = ref_byte(a + 32'(k));
    fill = (ext == 2'd0) ? 1'b0 : (ext == 2'd2) ? 1'b1 : v[8*n-1];
    for (int k = n; k < 4; k++) v[8*k +: 8] = {8{fill}};
    return v;
  endfunction

  // One access as the execute stage, second phase included when flagged
  task automatic run_access(input logic we, input logic [1:0] size, input logic [1:0] ext,
                            input logic [31:0] a, input logic [31:0] b, input logic incr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic [31:0] addr, exp_addr;
    logic [7:0]  span;
    logic [3:0]  exp_be;
    logic        done, mis, exp_mis;
    int          phases, resp, t;
    addr    = incr ? a + b : a;
    span    = {4'b0000, (size == 2'd0) ? 4'hF : (size == 2'd1) ? 4'h3 : 4'h1} << addr[1:0];
    exp_mis = (size == 2'd0 && addr[1:0] != 2'd0) || (size == 2'd1 && addr[1:0] == 2'd3);
    phases  = 1;
    resp    = 0;
    rdata   = '0;
    mis     = 1'b0;
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= we;
    data_type_ex_i       <= lsu_pkg::mem_size_e'(size);
    data_sign_ext_ex_i   <= lsu_pkg::ext_mode_e'(ext);
    data_wdata_ex_i      <= wdata;
    data_reg_offset_ex_i <= 2'd0;
    operand_a_ex_i       <= a;
    operand_b_ex_i       <= b;
    addr_useincr_ex_i    <= incr;
    data_misaligned_ex_i <= 1'b0;
    for (int ph = 0; ph < phases; ph++) begin
      exp_be   = (ph == 0) ? span[3:0] : span[7:4];
      exp_addr = (ph == 0) ? addr : {addr[31:2] + 30'd1, 2'b00};
      done     = 1'b0;
      t        = 0;
      while (!done && t < 100) begin
        @(posedge clk);
        t++;
        if (data_rvalid_i) begin
          resp++;
          rdata = data_rdata_ex_o;
        end
        if (data_req_o && data_gnt_i && (data_be_o != exp_be || data_addr_o != exp_addr))
          flag_error($sformatf("bus addr %h be %b, expected %h %b",
                               data_addr_o, data_be_o, exp_addr, exp_be));
        if (lsu_ready_ex_o) begin
          done = 1'b1;
          mis  = data_misaligned_o;
        end
      end
      if (!done) flag_error("Timed out waiting for lsu_ready_ex_o");
      if (ph == 0 && mis != exp_mis)
        flag_error($sformatf("misaligned flag %b at %h, expected %b", mis, addr, exp_mis));
      if (ph == 0 && mis) begin
        phases = 2;
        data_misaligned_ex_i <= 1'b1;
        operand_a_ex_i       <= addr + 32'd4;
        addr_useincr_ex_i    <= 1'b0;
      end
    end
    data_req_ex_i <= 1'b0;
    t = 0;
    while (resp < phases && t < 100) begin
      @(posedge clk);
      t++;
      if (data_rvalid_i) begin
        resp++;
        rdata = data_rdata_ex_o;  // Last response carries the result
      end
    end
    if (resp < phases) flag_error("Timed out waiting for data_rvalid_i");
    data_misaligned_ex_i <= 1'b0;
  endtask

  task automatic do_store(input logic [1:0] size, input logic [31:0] a, input logic [31:0] wd);
    logic [31:0] r;
    int          n;
    n = (size == 2'd0) ? 4 : (size == 2'd1) ? 2 : 1;
    run_access(1'b1, size, 2'd0, a, 32'd0, 1'b0, wd, r);
    for (int k = 0; k < n; k++) ref_mem[a + 32'(k)] = wd[8*k +: 8];
    for (int k = -4; k < 8; k++) begin  // Neighbors must stay untouched
      if (bus_byte(a + 32'(k)) != ref_byte(a + 32'(k)))
        flag_error($sformatf("memory byte %h is %h, expected %h", a + 32'(k),
                             bus_byte(a + 32'(k)), ref_byte(a + 32'(k))));
    end
  endtask

  task automatic do_load(input logic [1:0] size, input logic [1:0] ext, input logic [31:0] a);
    logic [31:0] r;
    run_access(1'b0, size, ext, a, 32'd0, 1'b0, 32'd0, r);
    if (r !== expect_load(a, size, ext))
      flag_error($sformatf("load %h size %0d ext %0d gave %h, expected %h",
                           a, size, ext, r, expect_load(a, size, ext)));
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic test_word_rw();
    logic [31:0] r;
    run_access(1'b1, 2'd0, 2'd0, 32'h100, 32'h20, 1'b1, 32'hCAFE_1234, r);
    ref_mem[32'h120] = 8'h34;
    ref_mem[32'h121] = 8'h12;
    ref_mem[32'h122] = 8'hFE;
    ref_mem[32'h123] = 8'hCA;
    // A alone with a nonzero B on the operand port
    run_access(1'b0, 2'd0, 2'd0, 32'h120, 32'h40, 1'b0, 32'd0, r);
    if (r !== 32'hCAFE_1234) flag_error($sformatf("A-only load gave %h", r));
    run_access(1'b0, 2'd0, 2'd0, 32'h118, 32'h8, 1'b1, 32'd0, r);
    if (r !== 32'hCAFE_1234) flag_error($sformatf("A+B load gave %h", r));
  endtask

  task automatic test_narrow_stores();
    for (int off = 0; off < 4; off++) begin
      do_store(2'd2, 32'h200 + 32'(off), 32'h0000_0011 * 32'(off + 1));
      do_store(2'd1, 32'h210 + 32'(off), 32'h0000_A0B0 + 32'(off));
    end
    do_load(2'd0, 2'd0, 32'h200);
    do_load(2'd0, 2'd0, 32'h210);
    do_load(2'd0, 2'd0, 32'h214);
  endtask

  task automatic test_narrow_loads();
    do_store(2'd0, 32'h300, 32'h8A7F_F09C);
    for (int off = 0; off < 4; off++) begin
      for (int ext = 0; ext < 4; ext++) begin
        do_load(2'd2, 2'(ext), 32'h300 + 32'(off));
        do_load(2'd1, 2'(ext), 32'h300 + 32'(off));
      end
    end
  endtask

  task automatic test_misaligned();
    for (int off = 1; off < 4; off++) begin
      do_load(2'd0, 2'd0, 32'h400 + 32'(off));  // Fill pattern across two words
      do_store(2'd0, 32'h500 + 32'(16 * off) + 32'(off), 32'h1357_9BDF ^ 32'(off));
      do_load(2'd0, 2'd0, 32'h500 + 32'(16 * off) + 32'(off));
    end
    do_load(2'd1, 2'd1, 32'h403);
    do_store(2'd1, 32'h533, 32'h0000_F00D);
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    logic [31:0] a_hold;
    block_gnt <= 1'b1;
    fork
      run_access(1'b0, 2'd0, 2'd0, 32'h300, 32'd0, 1'b0, 32'd0, r);
      begin
        repeat (2) @(posedge clk);
        a_hold = data_addr_o;
        for (int k = 0; k < 6; k++) begin
          @(posedge clk);
          if (!data_req_o || data_addr_o != a_hold || lsu_ready_ex_o)
            flag_error("request not held steady under a withheld grant");
        end
        block_gnt <= 1'b0;
      end
    join
    if (r !== expect_load(32'h300, 2'd0, 2'd0)) flag_error($sformatf("held load gave %h", r));
  endtask

  task automatic test_back_to_back();
    logic [31:0] rd [2];
    int          acc, rv, t;
    resp_extra <= 6;
    data_req_ex_i      <= 1'b1;
    data_we_ex_i       <= 1'b0;
    data_type_ex_i     <= lsu_pkg::SIZE_WORD;
    data_sign_ext_ex_i <= lsu_pkg::EXT_ZERO;
    operand_a_ex_i     <= 32'h700;
    addr_useincr_ex_i  <= 1'b0;
    acc = 0;
    rv  = 0;
    t   = 0;
    while (rv < 2 && t < 100) begin
      @(posedge clk);
      t++;
      if (!busy_o) flag_error("busy_o low with loads in flight");
      if (data_rvalid_i) begin
        rd[rv] = data_rdata_ex_o;
        rv++;
      end
      if (data_req_o && data_gnt_i) begin
        acc++;
        if (acc == 1) operand_a_ex_i <= 32'h704;
        if (acc == 2 && rv != 0) flag_error("second load not accepted before a response");
      end
      // Second load leaves EX only once lsu_ready_ex_o is seen
      if (acc == 2 && lsu_ready_ex_o) data_req_ex_i <= 1'b0;
    end
    if (rv < 2) flag_error("Timed out waiting for two load responses");
    resp_extra <= 0;
    @(posedge clk);
    if (busy_o || !lsu_ready_wb_o) flag_error("LSU not idle after the last response");
    if (rd[0] !== expect_load(32'h700, 2'd0, 2'd0) || rd[1] !== expect_load(32'h704, 2'd0, 2'd0))
      flag_error($sformatf("back-to-back loads gave %h %h", rd[0], rd[1]));
  endtask

  ////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    seed   = 52782;
    errors = 0;
    cyc    = 0;
    resp_extra = 0;
    block_gnt  = 1'b0;
    rst_n  = 1'b0;
    data_req_ex_i = 1'b0;
    data_we_ex_i  = 1'b0;
    data_type_ex_i = lsu_pkg::SIZE_WORD;
    data_sign_ext_ex_i = lsu_pkg::EXT_ZERO;
    data_wdata_ex_i = '0;
    data_reg_offset_ex_i = 2'd0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    addr_useincr_ex_i = 1'b0;
    data_misaligned_ex_i = 1'b0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (busy_o || !lsu_ready_wb_o || data_req_o) flag_error("LSU not idle after reset");
    test_word_rw();
    test_narrow_stores();
    test_narrow_loads();
    test_misaligned();
    test_backpressure();
    test_back_to_back();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(40 * 20000);
    $display("Simulation ran past its time limit");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
lsu_pkg.sv
lsu_req_format.sv
lsu_trans_ctrl.sv
lsu_rdata_align.sv
lsu_top.sv
tb_lsu.sv

// ==== Makefile ====
# Verilator build and run for the LSU testbench

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_lsu
RTL_TOP   ?= lsu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall lsu_pkg.sv lsu_req_format.sv lsu_trans_ctrl.sv \
		lsu_rdata_align.sv lsu_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
